// File: logic/decode_pkg.sv
package decode_pkg;

    // field and control widths
    typedef logic [31:0] inst_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [1:0]  alu_src_t;
    typedef logic [1:0]  wb_src_t;
    typedef logic [2:0]  pc_src_t;
    typedef logic [2:0]  width_t;
    typedef logic [2:0]  csr_src_t;
    typedef logic [1:0]  trap_t;

    localparam int ALU_OP_WIDTH = 4;

    // base opcodes
    localparam opcode_t OP_R        = 7'b0110011;
    localparam opcode_t OP_R32      = 7'b0111011;
    localparam opcode_t OP_I_IMM    = 7'b0010011;
    localparam opcode_t OP_I_IMM32  = 7'b0011011;
    localparam opcode_t OP_I_LOAD   = 7'b0000011;
    localparam opcode_t OP_S        = 7'b0100011;
    localparam opcode_t OP_B        = 7'b1100011;
    localparam opcode_t OP_I_JAL    = 7'b1101111;
    localparam opcode_t OP_I_JALR   = 7'b1100111;
    localparam opcode_t OP_U_LUI    = 7'b0110111;
    localparam opcode_t OP_U_AUIPC  = 7'b0010111;
    localparam opcode_t OP_I_SYSTEM = 7'b1110011;

    // register-register ALU
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;

    // immediate ALU
    localparam funct3_t FUNCT3_ADDI      = 3'b000;
    localparam funct3_t FUNCT3_SLLI      = 3'b001;
    localparam funct3_t FUNCT3_SLTI      = 3'b010;
    localparam funct3_t FUNCT3_SLTIU     = 3'b011;
    localparam funct3_t FUNCT3_XORI      = 3'b100;
    localparam funct3_t FUNCT3_SRLI_SRAI = 3'b101;
    localparam funct3_t FUNCT3_ORI       = 3'b110;
    localparam funct3_t FUNCT3_ANDI      = 3'b111;

    // loads and stores
    localparam funct3_t FUNCT3_LB  = 3'b000;
    localparam funct3_t FUNCT3_LH  = 3'b001;
    localparam funct3_t FUNCT3_LW  = 3'b010;
    localparam funct3_t FUNCT3_LD  = 3'b011;
    localparam funct3_t FUNCT3_LBU = 3'b100;
    localparam funct3_t FUNCT3_LHU = 3'b101;
    localparam funct3_t FUNCT3_LWU = 3'b110;
    localparam funct3_t FUNCT3_SB  = 3'b000;
    localparam funct3_t FUNCT3_SH  = 3'b001;
    localparam funct3_t FUNCT3_SW  = 3'b010;
    localparam funct3_t FUNCT3_SD  = 3'b011;

    // branches
    localparam funct3_t FUNCT3_BEQ  = 3'b000;
    localparam funct3_t FUNCT3_BNE  = 3'b001;
    localparam funct3_t FUNCT3_BLT  = 3'b100;
    localparam funct3_t FUNCT3_BGE  = 3'b101;
    localparam funct3_t FUNCT3_BLTU = 3'b110;
    localparam funct3_t FUNCT3_BGEU = 3'b111;

    // system
    localparam funct3_t FUNCT3_ECALL_EBREAK_MRET = 3'b000;
    localparam funct3_t FUNCT3_CSRRW  = 3'b001;
    localparam funct3_t FUNCT3_CSRRS  = 3'b010;
    localparam funct3_t FUNCT3_CSRRC  = 3'b011;
    localparam funct3_t FUNCT3_CSRRWI = 3'b101;
    localparam funct3_t FUNCT3_CSRRSI = 3'b110;
    localparam funct3_t FUNCT3_CSRRCI = 3'b111;

    localparam funct7_t FUNCT7_ADD  = 7'b0000000;
    localparam funct7_t FUNCT7_SUB  = 7'b0100000;
    localparam funct7_t FUNCT7_SRL  = 7'b0000000;
    localparam funct7_t FUNCT7_SRA  = 7'b0100000;
    localparam funct7_t FUNCT7_SRLI = 7'b0000000;
    localparam funct7_t FUNCT7_SRAI = 7'b0100000;
    localparam funct7_t FUNCT7_MRET = 7'b0011000;

    // operand, writeback, pc, width, csr and trap codes
    localparam alu_src_t SRC_A_RS1  = 2'd0;
    localparam alu_src_t SRC_A_PC   = 2'd1;
    localparam alu_src_t SRC_A_CSR  = 2'd2;
    localparam alu_src_t SRC_B_RS2  = 2'd0;
    localparam alu_src_t SRC_B_IMM  = 2'd1;
    localparam alu_src_t SRC_B_RS1  = 2'd2;
    localparam alu_src_t SRC_B_ZIMM = 2'd3;

    localparam wb_src_t WB_ALU = 2'd0;
    localparam wb_src_t WB_MEM = 2'd1;
    localparam wb_src_t WB_PC4 = 2'd2;
    localparam wb_src_t WB_CSR = 2'd3;

    localparam pc_src_t PC_NEXT    = 3'd0;
    localparam pc_src_t PC_BR_ZERO = 3'd1;
    localparam pc_src_t PC_BR_NZ   = 3'd2;
    localparam pc_src_t PC_JUMP    = 3'd4;
    localparam pc_src_t PC_CSR     = 3'd5;

    localparam width_t WIDTH_B = 3'd0;
    localparam width_t WIDTH_H = 3'd1;
    localparam width_t WIDTH_W = 3'd2;
    localparam width_t WIDTH_D = 3'd3;

    localparam csr_src_t CSR_SRC_ALU = 3'd0;
    localparam csr_src_t CSR_SRC_RS1 = 3'd2;

    localparam trap_t TRAP_NONE  = 2'd0;
    localparam trap_t TRAP_ECALL = 2'd1;
    localparam trap_t TRAP_MRET  = 2'd3;

    typedef enum logic [3:0] {
        CLASS_NONE, CLASS_R, CLASS_R32, CLASS_I, CLASS_I32, CLASS_LOAD, CLASS_STORE,
        CLASS_BRANCH, CLASS_JAL, CLASS_JALR, CLASS_LUI, CLASS_AUIPC, CLASS_SYSTEM
    } inst_class_e;

    typedef enum logic [ALU_OP_WIDTH-1:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_JALR, ALU_COPY2
    } alu_op_e;

    typedef struct packed {
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        wb_src_t mem_to_reg;
    } mem_ctrl_t;

    typedef struct packed {
        alu_src_t alu_a_src;
        alu_src_t alu_b_src;
        logic     alu_b_neg;
        alu_op_e  alu_op;
    } alu_ctrl_t;

    typedef struct packed {
        logic     csr_we;
        csr_src_t csr_src;
        trap_t    trap;
        pc_src_t  pc_src;
        width_t   data_width;
    } flow_ctrl_t;

    typedef struct packed {
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        wb_src_t  mem_to_reg;
        alu_src_t alu_a_src;
        alu_src_t alu_b_src;
        logic     alu_b_neg;
        alu_op_e  alu_op;
        logic     csr_we;
        csr_src_t csr_src;
        trap_t    trap;
        pc_src_t  pc_src;
        width_t   data_width;
    } ctrl_word_t;

endpackage

// File: logic/opcode_decode.sv
`timescale 1ns/1ps

module opcode_decode (
    input  decode_pkg::opcode_t     opcode,
    output decode_pkg::inst_class_e inst_class,
    output decode_pkg::mem_ctrl_t   mem,
    output logic                    bad_opcode
);
    import decode_pkg::*;

    always_comb begin
        inst_class     = CLASS_NONE;
        mem.mem_read   = 1'b0;
        mem.mem_write  = 1'b0;
        mem.reg_write  = 1'b1;
        mem.mem_to_reg = WB_ALU;
        bad_opcode     = 1'b0;
        case (opcode)
            OP_R:       inst_class = CLASS_R;
            OP_R32:     inst_class = CLASS_R32;
            OP_I_IMM:   inst_class = CLASS_I;
            OP_I_IMM32: inst_class = CLASS_I32;
            OP_U_LUI:   inst_class = CLASS_LUI;
            OP_U_AUIPC: inst_class = CLASS_AUIPC;
            OP_I_LOAD: begin
                inst_class     = CLASS_LOAD;
                mem.mem_read   = 1'b1;
                mem.mem_to_reg = WB_MEM;
            end
            OP_S: begin
                inst_class    = CLASS_STORE;
                mem.mem_write = 1'b1;
                mem.reg_write = 1'b0;
            end
            OP_B: begin
                inst_class    = CLASS_BRANCH;
                mem.reg_write = 1'b0;
            end
            OP_I_JAL: begin
                inst_class     = CLASS_JAL;
                mem.mem_to_reg = WB_PC4;
            end
            OP_I_JALR: begin
                inst_class     = CLASS_JALR;
                mem.mem_to_reg = WB_PC4;
            end
            // rd receives the old csr value
            OP_I_SYSTEM: begin
                inst_class     = CLASS_SYSTEM;
                mem.mem_to_reg = WB_CSR;
            end
            default: begin
                mem.reg_write = 1'b0;
                bad_opcode    = 1'b1;
            end
        endcase
    end

endmodule

// File: logic/alu_ctrl_decode.sv
`timescale 1ns/1ps

module alu_ctrl_decode (
    input  decode_pkg::inst_class_e inst_class,
    input  decode_pkg::funct3_t     funct3,
    input  decode_pkg::funct7_t     funct7,
    output decode_pkg::alu_ctrl_t   alu,
    output logic                    bad_funct
);
    import decode_pkg::*;

    logic shift_srl;
    logic shift_sra;

    // bit 25 is part of the rv64 shift amount for immediate shifts
    assign shift_srl = (funct7[6:1] == FUNCT7_SRLI[6:1]);
    assign shift_sra = (funct7[6:1] == FUNCT7_SRAI[6:1]);

    always_comb begin
        alu.alu_a_src = SRC_A_RS1;
        alu.alu_b_src = SRC_B_RS2;
        alu.alu_b_neg = 1'b0;
        alu.alu_op    = ALU_ADD;
        bad_funct     = 1'b0;
        case (inst_class)
            CLASS_R, CLASS_R32: begin
                case (funct3)
                    FUNCT3_ADD_SUB: begin
                        if (funct7 == FUNCT7_SUB)
                            alu.alu_op = ALU_SUB;
                        else if (funct7 != FUNCT7_ADD)
                            bad_funct = 1'b1;
                    end
                    FUNCT3_SLL:  alu.alu_op = ALU_SLL;
                    FUNCT3_SLT:  alu.alu_op = ALU_SLT;
                    FUNCT3_SLTU: alu.alu_op = ALU_SLTU;
                    FUNCT3_XOR:  alu.alu_op = ALU_XOR;
                    FUNCT3_SRL_SRA: begin
                        if (funct7 == FUNCT7_SRL)
                            alu.alu_op = ALU_SRL;
                        else if (funct7 == FUNCT7_SRA)
                            alu.alu_op = ALU_SRA;
                        else
                            bad_funct = 1'b1;
                    end
                    FUNCT3_OR:   alu.alu_op = ALU_OR;
                    FUNCT3_AND:  alu.alu_op = ALU_AND;
                    default:     bad_funct = 1'b1;
                endcase
                // word forms are ADDW, SUBW, SLLW, SRLW and SRAW only
                if (inst_class == CLASS_R32 &&
                    !(funct3 inside {FUNCT3_ADD_SUB, FUNCT3_SLL, FUNCT3_SRL_SRA}))
                    bad_funct = 1'b1;
            end
            CLASS_I, CLASS_I32: begin
                alu.alu_b_src = SRC_B_IMM;
                case (funct3)
                    FUNCT3_ADDI:  alu.alu_op = ALU_ADD;
                    FUNCT3_SLLI:  alu.alu_op = ALU_SLL;
                    FUNCT3_SLTI:  alu.alu_op = ALU_SLT;
                    FUNCT3_SLTIU: alu.alu_op = ALU_SLTU;
                    FUNCT3_XORI:  alu.alu_op = ALU_XOR;
                    FUNCT3_SRLI_SRAI: begin
                        if (shift_srl)
                            alu.alu_op = ALU_SRL;
                        else if (shift_sra)
                            alu.alu_op = ALU_SRA;
                        else
                            bad_funct = 1'b1;
                    end
                    FUNCT3_ORI:   alu.alu_op = ALU_OR;
                    FUNCT3_ANDI:  alu.alu_op = ALU_AND;
                    default:      bad_funct = 1'b1;
                endcase
                if (inst_class == CLASS_I32 &&
                    !(funct3 inside {FUNCT3_ADDI, FUNCT3_SLLI, FUNCT3_SRLI_SRAI}))
                    bad_funct = 1'b1;
            end
            CLASS_LOAD, CLASS_STORE: alu.alu_b_src = SRC_B_IMM;
            CLASS_BRANCH: begin
                if (funct3 inside {FUNCT3_BLT, FUNCT3_BGE})
                    alu.alu_op = ALU_SLT;
                else if (funct3 inside {FUNCT3_BLTU, FUNCT3_BGEU})
                    alu.alu_op = ALU_SLTU;
                else
                    alu.alu_op = ALU_SUB;
            end
            CLASS_JALR: begin
                alu.alu_b_src = SRC_B_IMM;
                alu.alu_op    = ALU_JALR;
            end
            CLASS_LUI: begin
                alu.alu_b_src = SRC_B_IMM;
                alu.alu_op    = ALU_COPY2;
            end
            CLASS_AUIPC: begin
                alu.alu_a_src = SRC_A_PC;
                alu.alu_b_src = SRC_B_IMM;
            end
            CLASS_SYSTEM: begin
                // set and clear forms combine the old csr with the mask
                case (funct3)
                    FUNCT3_CSRRW: alu.alu_b_src = SRC_B_RS1;
                    FUNCT3_CSRRS, FUNCT3_CSRRC, FUNCT3_CSRRSI, FUNCT3_CSRRCI: begin
                        alu.alu_a_src = SRC_A_CSR;
                        alu.alu_b_src = funct3[2] ? SRC_B_ZIMM : SRC_B_RS1;
                        alu.alu_b_neg = funct3[0];
                        alu.alu_op    = funct3[0] ? ALU_AND : ALU_OR;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: logic/flow_decode.sv
`timescale 1ns/1ps

module flow_decode (
    input  decode_pkg::inst_class_e inst_class,
    input  decode_pkg::funct3_t     funct3,
    input  decode_pkg::funct7_t     funct7,
    output decode_pkg::flow_ctrl_t  flow,
    output logic                    bad_flow
);
    import decode_pkg::*;

    always_comb begin
        flow.csr_we     = 1'b0;
        flow.csr_src    = CSR_SRC_ALU;
        flow.trap       = TRAP_NONE;
        flow.pc_src     = PC_NEXT;
        flow.data_width = WIDTH_D;
        bad_flow        = 1'b0;
        case (inst_class)
            CLASS_R32, CLASS_I32: flow.data_width = WIDTH_W;
            CLASS_LOAD: begin
                case (funct3)
                    FUNCT3_LB, FUNCT3_LBU: flow.data_width = WIDTH_B;
                    FUNCT3_LH, FUNCT3_LHU: flow.data_width = WIDTH_H;
                    FUNCT3_LW, FUNCT3_LWU: flow.data_width = WIDTH_W;
                    FUNCT3_LD:             flow.data_width = WIDTH_D;
                    default:               bad_flow = 1'b1;
                endcase
            end
            CLASS_STORE: begin
                case (funct3)
                    FUNCT3_SB: flow.data_width = WIDTH_B;
                    FUNCT3_SH: flow.data_width = WIDTH_H;
                    FUNCT3_SW: flow.data_width = WIDTH_W;
                    FUNCT3_SD: flow.data_width = WIDTH_D;
                    default:   bad_flow = 1'b1;
                endcase
            end
            CLASS_BRANCH: begin
                // taken on a zero ALU result for eq/ge, on nonzero for ne/lt
                case (funct3)
                    FUNCT3_BEQ, FUNCT3_BGE, FUNCT3_BGEU: flow.pc_src = PC_BR_ZERO;
                    FUNCT3_BNE, FUNCT3_BLT, FUNCT3_BLTU: flow.pc_src = PC_BR_NZ;
                    default:                             bad_flow = 1'b1;
                endcase
            end
            CLASS_JAL, CLASS_JALR: flow.pc_src = PC_JUMP;
            CLASS_SYSTEM: begin
                flow.data_width = WIDTH_W;
                case (funct3)
                    FUNCT3_ECALL_EBREAK_MRET: begin
                        if (funct7 == FUNCT7_MRET) begin
                            flow.trap   = TRAP_MRET;
                            flow.pc_src = PC_CSR;
                        end else begin
                            flow.trap = TRAP_ECALL;
                        end
                    end
                    FUNCT3_CSRRW, FUNCT3_CSRRWI: begin
                        flow.csr_we  = 1'b1;
                        flow.csr_src = CSR_SRC_RS1;
                    end
                    FUNCT3_CSRRS, FUNCT3_CSRRC, FUNCT3_CSRRSI, FUNCT3_CSRRCI:
                        flow.csr_we = 1'b1;
                    default: bad_flow = 1'b1;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  decode_pkg::inst_t      inst,
    output logic                   out_valid,
    output decode_pkg::ctrl_word_t ctrl,
    output logic                   illegal
);
    import decode_pkg::*;

    opcode_t     opcode;
    funct3_t     funct3;
    funct7_t     funct7;
    inst_class_e inst_class;
    mem_ctrl_t   mem;
    alu_ctrl_t   alu;
    flow_ctrl_t  flow;
    logic        bad_opcode;
    logic        bad_funct;
    logic        bad_flow;
    logic        illegal_d;
    ctrl_word_t  ctrl_d;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    opcode_decode u_opcode (
        .opcode     (opcode),
        .inst_class (inst_class),
        .mem        (mem),
        .bad_opcode (bad_opcode)
    );

    alu_ctrl_decode u_alu (
        .inst_class (inst_class),
        .funct3     (funct3),
        .funct7     (funct7),
        .alu        (alu),
        .bad_funct  (bad_funct)
    );

    flow_decode u_flow (
        .inst_class (inst_class),
        .funct3     (funct3),
        .funct7     (funct7),
        .flow       (flow),
        .bad_flow   (bad_flow)
    );

    assign illegal_d = bad_opcode | bad_funct | bad_flow;

    always_comb begin
        ctrl_d = {mem, alu, flow};
        // an illegal word must not change any architectural state
        if (illegal_d) begin
            ctrl_d.mem_read  = 1'b0;
            ctrl_d.mem_write = 1'b0;
            ctrl_d.reg_write = 1'b0;
            ctrl_d.csr_we    = 1'b0;
            ctrl_d.trap      = TRAP_NONE;
            ctrl_d.pc_src    = PC_NEXT;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            ctrl      <= '0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                ctrl    <= ctrl_d;
                illegal <= illegal_d;
            end
        end
    end

    mem_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !(ctrl.mem_read && ctrl.mem_write));

endmodule

// File: testbench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// integer ALU operation from funct3 and funct7
function automatic alu_op_e arith_op(input funct3_t f3, input funct7_t f7, input logic imm,
                                     output logic bad);
    funct7_t sh;
    bad = 1'b0;
    arith_op = ALU_ADD;
    // immediate shifts compare only funct7[6:1]
    sh = imm ? {f7[6:1], 1'b0} : f7;
    case (f3)
        3'd0: begin
            if (!imm && f7 == 7'b0100000)
                arith_op = ALU_SUB;
            else if (!imm && f7 != 7'b0000000)
                bad = 1'b1;
        end
        3'd1: arith_op = ALU_SLL;
        3'd2: arith_op = ALU_SLT;
        3'd3: arith_op = ALU_SLTU;
        3'd4: arith_op = ALU_XOR;
        3'd5: begin
            if (sh == 7'b0000000)
                arith_op = ALU_SRL;
            else if (sh == 7'b0100000)
                arith_op = ALU_SRA;
            else
                bad = 1'b1;
        end
        3'd6: arith_op = ALU_OR;
        default: arith_op = ALU_AND;
    endcase
endfunction

// expected control word and illegal flag of one instruction
function automatic ctrl_word_t model_decode(input inst_t w, output logic bad);
    ctrl_word_t c;
    funct3_t    f3;
    funct7_t    f7;
    logic       imm;
    logic       clear;
    c = '0;
    c.data_width = WIDTH_D;
    bad = 1'b0;
    f3 = w[14:12];
    f7 = w[31:25];
    imm = (w[6:0] == OP_I_IMM) || (w[6:0] == OP_I_IMM32);
    case (w[6:0])
        OP_R, OP_R32, OP_I_IMM, OP_I_IMM32: begin
            c.reg_write = 1'b1;
            c.alu_op = arith_op(f3, f7, imm, bad);
            if (imm)
                c.alu_b_src = SRC_B_IMM;
            if (w[6:0] == OP_R32 || w[6:0] == OP_I_IMM32) begin
                c.data_width = WIDTH_W;
                // only add, sub and shifts exist as word forms
                if (!(f3 inside {3'd0, 3'd1, 3'd5}))
                    bad = 1'b1;
            end
        end
        OP_I_LOAD: begin
            c.mem_read = 1'b1;
            c.reg_write = 1'b1;
            c.mem_to_reg = WB_MEM;
            c.alu_b_src = SRC_B_IMM;
            // size sits in the low two funct3 bits
            c.data_width = {1'b0, f3[1:0]};
            bad = (f3 == 3'b111);
        end
        OP_S: begin
            c.mem_write = 1'b1;
            c.alu_b_src = SRC_B_IMM;
            c.data_width = {1'b0, f3[1:0]};
            bad = f3[2];
        end
        OP_B: begin
            if (f3[2:1] == 2'b10)
                c.alu_op = ALU_SLT;
            else if (f3[2:1] == 2'b11)
                c.alu_op = ALU_SLTU;
            else
                c.alu_op = ALU_SUB;
            c.pc_src = (f3 inside {3'd0, 3'd5, 3'd7}) ? PC_BR_ZERO : PC_BR_NZ;
            bad = (f3[2:1] == 2'b01);
        end
        OP_I_JAL, OP_I_JALR: begin
            c.reg_write = 1'b1;
            c.mem_to_reg = WB_PC4;
            c.pc_src = PC_JUMP;
            if (w[6:0] == OP_I_JALR) begin
                c.alu_b_src = SRC_B_IMM;
                c.alu_op = ALU_JALR;
            end
        end
        OP_U_LUI: begin
            c.reg_write = 1'b1;
            c.alu_b_src = SRC_B_IMM;
            c.alu_op = ALU_COPY2;
        end
        OP_U_AUIPC: begin
            c.reg_write = 1'b1;
            c.alu_a_src = SRC_A_PC;
            c.alu_b_src = SRC_B_IMM;
        end
        OP_I_SYSTEM: begin
            c.reg_write = 1'b1;
            c.mem_to_reg = WB_CSR;
            c.data_width = WIDTH_W;
            if (f3 == 3'b000) begin
                c.trap = (f7 == FUNCT7_MRET) ? TRAP_MRET : TRAP_ECALL;
                if (f7 == FUNCT7_MRET)
                    c.pc_src = PC_CSR;
            end else if (f3 == 3'b100) begin
                bad = 1'b1;
            end else if (f3[1:0] == 2'b01) begin
                // csrrw and csrrwi write the source straight through
                c.csr_we = 1'b1;
                c.csr_src = CSR_SRC_RS1;
                if (!f3[2])
                    c.alu_b_src = SRC_B_RS1;
            end else begin
                // clear forms AND the old value with the inverted mask
                clear = (f3 == 3'd3) || (f3 == 3'd7);
                c.csr_we = 1'b1;
                c.alu_a_src = SRC_A_CSR;
                c.alu_b_src = (f3 >= 3'd6) ? SRC_B_ZIMM : SRC_B_RS1;
                c.alu_b_neg = clear;
                c.alu_op = clear ? ALU_AND : ALU_OR;
            end
        end
        default: bad = 1'b1;
    endcase
    if (bad) begin
        c.mem_read = 1'b0;
        c.mem_write = 1'b0;
        c.reg_write = 1'b0;
        c.csr_we = 1'b0;
        c.trap = TRAP_NONE;
        c.pc_src = PC_NEXT;
    end
    return c;
endfunction

// opcode from ops[lo..hi] with random fields, or a fully random word
function automatic inst_t random_inst(input int lo, input int hi, input int wild);
    opcode_t ops [12];
    inst_t   w;
    int      pick;
    ops = '{OP_R, OP_R32, OP_I_IMM, OP_I_IMM32, OP_I_LOAD, OP_S, OP_B,
            OP_I_JAL, OP_I_JALR, OP_U_LUI, OP_U_AUIPC, OP_I_SYSTEM};
    w = $random(seed);
    if (($random(seed) & wild) == 0)
        return w;
    pick = lo + $unsigned($random(seed)) % (hi - lo + 1);
    w[6:0] = ops[pick];
    // steer funct7 toward sub, sra and mret
    case ($unsigned($random(seed)) % 4)
        0: w[31:25] = 7'b0000000;
        1: w[31:25] = 7'b0100000;
        2: w[31:25] = FUNCT7_MRET;
        default: ;
    endcase
    // shamt[5] of rv64 immediate shifts
    if (w[6:0] == OP_I_IMM)
        w[25] = ($random(seed) & 1) != 0;
    return w;
endfunction

`endif

// File: testbench/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    typedef struct packed {
        ctrl_word_t ctrl;
        logic       illegal;
    } expect_t;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    inst_t      inst;
    logic       out_valid;
    ctrl_word_t ctrl;
    logic       illegal;

    integer  seed = 59;
    expect_t exp_q[$];
    expect_t last_exp = '0;
    int      checks = 0;
    int      errors = 0;
    int      tests = 0;
    logic    checking = 1'b0;
    logic    prev_valid = 1'b0;

    `include "decode_model.svh"

    decode_stage dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .inst      (inst),
        .out_valid (out_valid),
        .ctrl      (ctrl),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_ctrl(input string name, input ctrl_word_t got, input ctrl_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_e got, input alu_op_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic compare_output(input expect_t e);
        check_bit("illegal", illegal, e.illegal);
        if (e.illegal) begin
            check_bit("ctrl.mem_read", ctrl.mem_read, 1'b0);
            check_bit("ctrl.mem_write", ctrl.mem_write, 1'b0);
            check_bit("ctrl.reg_write", ctrl.reg_write, 1'b0);
            check_bit("ctrl.csr_we", ctrl.csr_we, 1'b0);
            check_bit("ctrl.trap|pc_src", |{ctrl.trap, ctrl.pc_src}, 1'b0);
        end else begin
            check_ctrl("ctrl", ctrl, e.ctrl);
            check_alu_op("ctrl.alu_op", ctrl.alu_op, e.ctrl.alu_op);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            check_bit("out_valid", out_valid, prev_valid);
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("out_valid set at %0t with no instruction pending", $time);
                end else begin
                    last_exp = exp_q.pop_front();
                    compare_output(last_exp);
                end
            end else begin
                // idle cycles keep the last decoded word
                compare_output(last_exp);
            end
        end
        prev_valid = in_valid;
    end

    task automatic run_test(input string name, input int lo, input int hi, input int wild,
                            input int count);
        int         start_err;
        int         start_chk;
        int         wait_cycles;
        inst_t      w;
        logic       v;
        logic       bad;
        expect_t    e;
        start_err = errors;
        start_chk = checks;
        repeat (count) begin
            @(posedge clk);
            v = ($unsigned($random(seed)) % 4) != 0;
            w = random_inst(lo, hi, wild);
            in_valid <= v;
            inst <= w;
            if (v) begin
                e.ctrl = model_decode(w, bad);
                e.illegal = bad;
                exp_q.push_back(e);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 10) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s: %0d decoded words never came out", name, exp_q.size());
            $display("Test failed");
            $finish;
        end
        tests++;
        $display("%s: %0d checks, %0d errors", name, checks - start_chk, errors - start_err);
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        inst = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("illegal", illegal, 1'b0);
        check_ctrl("ctrl", ctrl, '0);
        tests++;
        $display("reset values: %0d checks, %0d errors", checks, errors);
        checking = 1'b1;

        run_test("alu classes", 0, 3, 7, 200);
        run_test("loads and stores", 4, 5, 7, 150);
        run_test("branches and jumps", 6, 10, 7, 200);
        run_test("system", 11, 11, 7, 150);
        run_test("random words", 0, 11, 0, 200);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+testbench
logic/decode_pkg.sv
logic/opcode_decode.sv
logic/alu_ctrl_decode.sv
logic/flow_decode.sv
logic/decode_stage.sv
testbench/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - logic/decode_pkg.sv
  - logic/opcode_decode.sv
  - logic/alu_ctrl_decode.sv
  - logic/flow_decode.sv
  - logic/decode_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_decode_stage.sv
